// File: flist.f
mel_pkg.sv
mel_weighted_if.sv
mel_weight_stage.sv
mel_accumulate_stage.sv
mel_log_stage.sv
mel_frame_collect.sv
mel_filter_bank_top.sv
mel_assertions.sv
tb_mel_filter_bank.sv

// File: mel_accumulate_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mel_accumulate_stage (
    input  wire                          clk,
    input  wire                          reset,
    mel_weighted_if.consumer             wbus,
    output logic                         energy_valid, // one strobe per finished filter
    output logic [mel_pkg::ENERGY_W-1:0] energy,
    output logic                         energy_last   // frame boundary
);
    import mel_pkg::*;

    logic [ENERGY_W-1:0] rising;   // rising side of the filter now ramping up
    logic [ENERGY_W-1:0] falling;  // falling side of the filter ramping down
    logic [ENERGY_W-1:0] rise_sum; // shared adder, update and reload
    logic [ENERGY_W-1:0] fall_sum;
    logic [1:0]          edge_cnt; // edges seen this frame, saturates at 2
    logic                primed;   // both sides hold real filters

    assign rise_sum = rising + wbus.product;
    assign fall_sum = falling + wbus.inverse; // inverse is 0 on an edge
    assign primed   = edge_cnt[1];

    //////////////////////////////////////////////////
    // sums and strobes
    //////////////////////////////////////////////////
    // at each edge the rising side of filter j+1 turns into its falling side,
    // and the falling side of filter j is done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rising       <= '0;
            falling      <= '0;
            edge_cnt     <= '0;
            energy_valid <= 1'b0;
            energy_last  <= 1'b0;
        end else begin
            energy_valid <= 1'b0; // strobes last one cycle
            energy_last  <= 1'b0;
            if (wbus.valid) begin
                if (wbus.at_edge) begin
                    if (primed) begin
                        energy_valid <= 1'b1;
                    end else begin
                        edge_cnt <= edge_cnt + 1'b1; // first two edges only prime
                    end
                    falling <= rise_sum; // peak bin closes the rising side
                    rising  <= '0;
                end else begin
                    rising  <= rise_sum;
                    falling <= fall_sum;
                end
                if (wbus.last) begin
                    rising      <= '0;   // fresh start for the next frame
                    falling     <= '0;
                    edge_cnt    <= '0;
                    energy_last <= 1'b1;
                end
            end
        end
    end

    // finished energy
    always_ff @(posedge clk) begin
        if (wbus.valid && wbus.at_edge) begin
            energy <= fall_sum;
        end
    end

endmodule

`default_nettype wire

// File: mel_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mel_assertions (
    input wire                                           clk,
    input wire                                           reset,
    input wire                                           s_valid,
    input wire                                           s_ready,
    input wire                                           m_valid,
    input wire                                           m_ready,
    input wire [mel_pkg::NUM_FILTERS*mel_pkg::LOG_W-1:0] mel_energy,
    input wire [$clog2(mel_pkg::NUM_BINS)-1:0]           bin_cnt // next bin index in the dut
);
    import mel_pkg::*;

    localparam int CNT_W = $clog2(NUM_BINS);

    int               fail_count = 0; // failed assertions so far
    logic [CNT_W-1:0] taken;          // bins handed over in this frame
    logic             last_accept;

    assign last_accept = s_valid && s_ready && (taken == CNT_W'(NUM_BINS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            taken <= '0;
        end else if (s_valid && s_ready) begin
            taken <= last_accept ? '0 : taken + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // handshake and timing
    //////////////////////////////////////////////////
    // m_valid set on edge t+4 shows in the samples of tick t+5
    last_to_valid: assert property (@(posedge clk) disable iff (reset)
        $past(last_accept, 5) |-> $rose(m_valid)) else begin
        $error("m_valid did not rise 4 cycles after the last bin");
        fail_count++;
    end

    valid_from_last: assert property (@(posedge clk) disable iff (reset)
        $rose(m_valid) |-> $past(last_accept, 5)) else begin
        $error("m_valid rose without a last bin 4 cycles before");
        fail_count++;
    end

    hold_output: assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(mel_energy)) else begin
        $error("output changed while m_ready was low");
        fail_count++;
    end

    ready_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(s_ready && m_valid)) else begin
        $error("s_ready high while m_valid high");
        fail_count++;
    end

    // bin counter only moves on a real handshake
    no_accept_closed: assert property (@(posedge clk) disable iff (reset)
        !s_ready |=> $stable(bin_cnt)) else begin
        $error("bin taken while s_ready was low");
        fail_count++;
    end

endmodule

bind mel_filter_bank_top mel_assertions mel_assertions_inst (
    .clk        (clk),
    .reset      (reset),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .mel_energy (mel_energy),
    .bin_cnt    (mel_weight_stage_inst.bin_cnt)
);

`default_nettype wire

// File: mel_filter_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module mel_filter_bank_top (
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire                                            s_valid,
    output logic                                           s_ready,
    input  wire [mel_pkg::BIN_W-1:0]                       bin_power,
    output logic                                           m_valid,
    input  wire                                            m_ready,
    output logic [mel_pkg::NUM_FILTERS*mel_pkg::LOG_W-1:0] mel_energy
);
    import mel_pkg::*;

    logic                energy_valid;
    logic [ENERGY_W-1:0] energy;
    logic                energy_last;
    logic                log_valid;
    logic [LOG_W-1:0]    log_energy;
    logic                log_last;
    logic                frame_taken; // back from the collector, reopens the input

    mel_weighted_if wbus ();          // weighted samples

    //////////////////////////////////////////////////
    // four stage pipeline
    //////////////////////////////////////////////////
    mel_weight_stage mel_weight_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .bin_power   (bin_power),
        .frame_taken (frame_taken),
        .wbus        (wbus.producer)
    );

    mel_accumulate_stage mel_accumulate_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .wbus         (wbus.consumer),
        .energy_valid (energy_valid),
        .energy       (energy),
        .energy_last  (energy_last)
    );

    mel_log_stage mel_log_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .energy_valid (energy_valid),
        .energy       (energy),
        .energy_last  (energy_last),
        .log_valid    (log_valid),
        .log_energy   (log_energy),
        .log_last     (log_last)
    );

    mel_frame_collect mel_frame_collect_inst (
        .clk         (clk),
        .reset       (reset),
        .log_valid   (log_valid),
        .log_energy  (log_energy),
        .log_last    (log_last),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .mel_energy  (mel_energy),
        .frame_taken (frame_taken)
    );

endmodule

`default_nettype wire

// File: mel_frame_collect.sv
`timescale 1ns/1ps
`default_nettype none

module mel_frame_collect (
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire                                          log_valid,
    input  wire [mel_pkg::LOG_W-1:0]                     log_energy,
    input  wire                                          log_last,
    output logic                                         m_valid,
    input  wire                                          m_ready,
    output logic [mel_pkg::NUM_FILTERS*mel_pkg::LOG_W-1:0] mel_energy,
    output logic                                         frame_taken // to the weighting stage
);
    import mel_pkg::*;

    localparam int BANK_W = NUM_FILTERS * LOG_W;

    collect_state_t      state;
    logic [BANK_W-1:0]   bank; // filter 0 lands in the low slot after a full frame

    assign m_valid     = (state == HOLD);
    assign frame_taken = m_valid && m_ready; // single cycle, leaves HOLD on this edge
    assign mel_energy  = bank;

    //////////////////////////////////////////////////
    // collect and hold
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= COLLECT;
            bank  <= '0;     // output bus low out of reset
        end else begin
            case (state)
                COLLECT: begin
                    if (log_valid) begin
                        bank <= {log_energy, bank[BANK_W-1:LOG_W]}; // newest on top
                    end
                    if (log_last) begin
                        state <= HOLD; // m_valid on the same edge as the last strobe
                    end
                end
                HOLD: begin
                    // bank frozen, input side is closed so no strobes arrive
                    if (m_ready) begin
                        state <= COLLECT;
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mel_log_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mel_log_stage (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          energy_valid,
    input  wire [mel_pkg::ENERGY_W-1:0]  energy,
    input  wire                          energy_last,
    output logic                         log_valid,
    output logic [mel_pkg::LOG_W-1:0]    log_energy, // Q5.11 log2
    output logic                         log_last
);
    import mel_pkg::*;

    localparam int POS_W  = $clog2(ENERGY_W); // integer part of 5 bits
    localparam int MANT_W = LOG_W - POS_W;    // fraction part of 11 bits

    logic [POS_W-1:0]    lead;   // position of the leading one
    logic [POS_W-1:0]    shift;  // brings the leading one to the msb
    logic [ENERGY_W-1:0] norm;
    logic [MANT_W-1:0]   mant;   // bits right below the leading one
    logic [LOG_W-1:0]    log_value;

    //////////////////////////////////////////////////
    // leading one and mantissa
    //////////////////////////////////////////////////
    always_comb begin
        lead = '0;
        for (int i = 0; i < ENERGY_W; i++) begin
            if (energy[i]) begin
                lead = POS_W'(i); // highest set bit wins
            end
        end
    end

    assign shift = POS_W'(ENERGY_W - 1) - lead;
    assign norm  = energy << shift;                   // zeros fill in on the right
    assign mant  = norm[ENERGY_W-2 -: MANT_W];        // drop the leading one itself
    assign log_value = {lead, mant}; // zero energy gives lead 0 and mant 0 as well

    // strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            log_valid <= 1'b0;
            log_last  <= 1'b0;
        end else begin
            log_valid <= energy_valid;
            log_last  <= energy_last;
        end
    end

    always_ff @(posedge clk) begin
        if (energy_valid) begin
            log_energy <= log_value;
        end
    end

endmodule

`default_nettype wire

// File: mel_pkg.sv
`default_nettype none

package mel_pkg;

    //////////////////////////////////////////////////
    // frame and bank sizes
    //////////////////////////////////////////////////
    localparam int NUM_BINS    = 64;              // power bins per frame
    localparam int NUM_FILTERS = 8;               // triangles in the bank
    localparam int NUM_EDGES   = NUM_FILTERS + 2; // start, peak and end points

    localparam int BIN_W    = 24; // unsigned power bin
    localparam int ENERGY_W = 32; // 64 bins of 24 bits cannot overflow this
    localparam int LOG_W    = 16; // log2 result in Q5.11
    localparam int WEIGHT_W = 16; // Q1.15 coefficient

    localparam int WEIGHT_ONE = 32768; // 1.0 in Q1.15

    // edge bins of the triangles, wider apart toward the top of the spectrum
    localparam int MEL_EDGES [NUM_EDGES] = '{1, 4, 8, 13, 19, 26, 34, 43, 53, 63};

    //////////////////////////////////////////////////
    // coefficient of one bin
    //////////////////////////////////////////////////
    // each segment between two edges ramps from just above 0 up to 1.0 at its top edge
    // the falling share of the previous filter is 1.0 minus this value
    function automatic logic [WEIGHT_W-1:0] bin_weight(input int bin);
        int lo;
        int hi;
        logic [WEIGHT_W-1:0] w;
        w = '0;                        // below the first edge and past the last
        if (bin == MEL_EDGES[0]) begin
            w = WEIGHT_W'(WEIGHT_ONE); // first edge starts filter 0
        end
        for (int i = 0; i < NUM_EDGES - 1; i++) begin
            lo = MEL_EDGES[i];
            hi = MEL_EDGES[i + 1];
            if (bin > lo && bin <= hi) begin
                w = WEIGHT_W'(((bin - lo) * WEIGHT_ONE) / (hi - lo)); // truncated
            end
        end
        return w;
    endfunction

    // frame collector
    typedef enum logic {
        COLLECT, // shifting log energies in
        HOLD     // frame offered on the output
    } collect_state_t;

endpackage

`default_nettype wire

// File: mel_weight_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mel_weight_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      s_valid,
    output logic                     s_ready,
    input  wire [mel_pkg::BIN_W-1:0] bin_power,
    input  wire                      frame_taken, // output handshake done, open input again
    mel_weighted_if.producer         wbus
);
    import mel_pkg::*;

    localparam int CNT_W  = $clog2(NUM_BINS);
    localparam int MULT_W = BIN_W + WEIGHT_W; // full product width
    localparam int FRAC   = WEIGHT_W - 1;     // Q1.15 fraction bits

    logic [CNT_W-1:0]    bin_cnt;  // index of the next bin to arrive
    logic [WEIGHT_W-1:0] weight;   // coefficient of that bin
    logic                accept;
    logic                is_last;
    logic                hold;     // frame fully taken in, waiting for the output side

    // first multiplier step
    logic                s1_valid;
    logic                s1_edge;
    logic                s1_last;
    logic [MULT_W-1:0]   s1_mult;
    logic [BIN_W-1:0]    s1_bin;   // kept for the falling share

    logic [ENERGY_W-1:0] scaled;   // product back in bin units

    assign accept  = s_valid && s_ready;
    assign is_last = (bin_cnt == CNT_W'(NUM_BINS - 1));
    assign weight  = bin_weight(int'(bin_cnt)); // small constant rom
    assign scaled  = ENERGY_W'(s1_mult[MULT_W-1:FRAC]);

    //////////////////////////////////////////////////
    // input side control
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bin_cnt <= '0;
            hold    <= 1'b0;
            s_ready <= 1'b0; // low in reset, high on the first clock after
        end else begin
            if (accept) begin
                bin_cnt <= is_last ? '0 : bin_cnt + 1'b1; // wrap at NUM_BINS
            end
            if (accept && is_last) begin
                hold    <= 1'b1; // stop on the frame boundary
                s_ready <= 1'b0;
            end else if (frame_taken) begin
                hold    <= 1'b0;
                s_ready <= 1'b1;
            end else begin
                s_ready <= !hold;
            end
        end
    end

    // flags through both multiplier steps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            s1_edge      <= 1'b0;
            s1_last      <= 1'b0;
            wbus.valid   <= 1'b0;
            wbus.at_edge <= 1'b0;
            wbus.last    <= 1'b0;
        end else begin
            s1_valid     <= accept;
            s1_edge      <= (weight == WEIGHT_W'(WEIGHT_ONE)); // peak or end of a triangle
            s1_last      <= is_last;
            wbus.valid   <= s1_valid;
            wbus.at_edge <= s1_edge;
            wbus.last    <= s1_last;
        end
    end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        s1_mult      <= bin_power * weight; // step one, registered product
        s1_bin       <= bin_power;
        wbus.product <= scaled;             // step two, output register
        wbus.inverse <= ENERGY_W'(s1_bin) - scaled; // never negative, weight <= 1.0
    end

endmodule

`default_nettype wire

// File: mel_weighted_if.sv
`timescale 1ns/1ps
`default_nettype none

// weighted samples from the weighting stage into the accumulators
// one strobe per bin, no back-pressure
interface mel_weighted_if;
    import mel_pkg::*;

    logic                valid;   // one cycle per sample
    logic [ENERGY_W-1:0] product; // bin * weight >> 15, rising share
    logic [ENERGY_W-1:0] inverse; // bin - product, falling share
    logic                at_edge; // weight was exactly 1.0
    logic                last;    // bin NUM_BINS-1

    modport producer (
        output valid, product, inverse, at_edge, last
    );

    modport consumer (
        input valid, product, inverse, at_edge, last
    );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mel_filter_bank -f flist.f -o sim_mel

status=0
./obj_dir/sim_mel +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
    exit 1
fi

// File: tb_mel_filter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mel_filter_bank;
    import mel_pkg::*;

    localparam int BANK_W  = NUM_FILTERS * LOG_W;
    localparam int FRAC_W  = 11;   // mantissa bits of the Q5.11 log
    localparam int TIMEOUT = 1000; // cycles allowed for any single wait

    logic              clk = 1'b0;
    logic              reset;
    logic              s_valid;
    logic              s_ready;
    logic [BIN_W-1:0]  bin_power;
    logic              m_valid;
    logic              m_ready;
    logic [BANK_W-1:0] mel_energy;

    logic [31:0]       lfsr;                  // stimulus generator state
    logic [BIN_W-1:0]  frame_bins [NUM_BINS]; // bins of the frame being sent
    logic [BANK_W-1:0] last_out;              // bank seen by the latest output check
    logic [BANK_W-1:0] steady_out;
    int                test_errors;
    int                error_count;
    int                test_count;
    int                failed_tests;
    int                assert_fails;

    mel_filter_bank_top mel_filter_bank_top_inst (
        .clk        (clk),
        .reset      (reset),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .bin_power  (bin_power),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .mel_energy (mel_energy)
    );

    always #20 clk = ~clk; // 40 ns period

    //////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////
    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [BIN_W-1:0] random_bin();
        logic [BIN_W-1:0] v;
        v = '0;
        for (int i = 0; i < BIN_W; i++) begin
            v = {v[BIN_W-2:0], lfsr_bit()}; // one step per bit
        end
        return v;
    endfunction

    // rising bins and the peak take the truncated product and falling bins take the rest
    function automatic logic [ENERGY_W-1:0] filter_energy(input int j);
        longint sum;
        longint prod;
        sum = 0;
        for (int b = MEL_EDGES[j] + 1; b <= MEL_EDGES[j + 2]; b++) begin
            prod = (longint'(frame_bins[b]) * longint'(bin_weight(b))) >> 15;
            if (b <= MEL_EDGES[j + 1]) begin
                sum += prod;
            end else begin
                sum += longint'(frame_bins[b]) - prod;
            end
        end
        return ENERGY_W'(sum);
    endfunction

    // integer part is the leading one position and the fraction the bits right below it
    function automatic logic [LOG_W-1:0] log_q511(input logic [ENERGY_W-1:0] e);
        int               p;
        logic [FRAC_W-1:0] mant;
        p = 0;
        for (int i = 0; i < ENERGY_W; i++) begin
            if (e[i]) p = i;
        end
        if (p >= FRAC_W) mant = FRAC_W'(e >> (p - FRAC_W));
        else mant = FRAC_W'(e << (FRAC_W - p)); // zero padded on the right
        return (e == '0) ? '0 : {(LOG_W - FRAC_W)'(p), mant};
    endfunction

    task automatic note_failure(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic fill_frame(input bit use_lfsr, input logic [BIN_W-1:0] level);
        for (int b = 0; b < NUM_BINS; b++) begin
            frame_bins[b] = use_lfsr ? random_bin() : level;
        end
    endtask

    // drive on the rising edge and look at the handshake half a cycle later
    task automatic send_frame(input bit gaps);
        int b;
        int stall;
        b     = 0;
        stall = 0;
        while (b < NUM_BINS && stall < TIMEOUT) begin
            @(posedge clk);
            if (gaps && lfsr_bit()) begin
                s_valid <= 1'b0; // idle cycle
            end else begin
                s_valid   <= 1'b1;
                bin_power <= frame_bins[b];
            end
            @(negedge clk);
            if (s_valid && s_ready) begin
                b++;             // taken on the coming edge
                stall = 0;
            end else begin
                stall++;
            end
        end
        @(posedge clk);
        s_valid <= 1'b0;
        if (b < NUM_BINS) begin
            $display("timeout: input stalled after %0d of %0d bins", b, NUM_BINS);
            test_errors++;
        end
    endtask

    task automatic check_frame(input string name);
        logic [LOG_W-1:0] expected;
        logic [LOG_W-1:0] got;
        int               cycles;
        cycles = 0;
        @(negedge clk);
        while (!m_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!m_valid) begin
            $display("timeout: no output frame for %s after %0d cycles", name, TIMEOUT);
            test_errors++;
        end else begin
            last_out = mel_energy;
            for (int j = 0; j < NUM_FILTERS; j++) begin
                expected = log_q511(filter_energy(j));
                got      = mel_energy[j*LOG_W +: LOG_W];
                assert (got == expected) else
                    note_failure($sformatf("%s filter %0d got %h expected %h",
                                           name, j, got, expected));
            end
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, test_errors);
            failed_tests++;
        end
        error_count += test_errors;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        reset        = 1'b1;
        s_valid      = 1'b0;
        bin_power    = '0;
        m_ready      = 1'b1;
        lfsr         = 32'h99925a26;
        test_errors  = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);                       // s_ready comes up here
        @(negedge clk);
        assert (!m_valid && s_ready && mel_energy == '0) else
            note_failure("outputs wrong after reset");
        finish_test("reset state");

        fill_frame(1'b0, BIN_W'(4096));
        send_frame(1'b0);
        check_frame("constant frame");
        finish_test("constant frame");

        for (int f = 0; f < 3; f++) begin     // m_ready stays high throughout
            fill_frame(1'b1, '0);
            send_frame(1'b0);
            check_frame($sformatf("random frame %0d", f));
        end
        finish_test("random frames");

        fill_frame(1'b1, '0);
        send_frame(1'b0);
        check_frame("frame without gaps");
        steady_out = last_out;
        send_frame(1'b1);                     // same bins with random idle cycles
        check_frame("frame with gaps");
        assert (last_out == steady_out) else note_failure("gapped frame differs");
        finish_test("gapped input");

        @(posedge clk);
        m_ready <= 1'b0;
        fill_frame(1'b1, '0);
        send_frame(1'b0);
        check_frame("held frame");
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            s_valid   <= 1'b1;                // offered while the input is closed
            bin_power <= random_bin();
            @(negedge clk);
            assert (m_valid && !s_ready && mel_energy == last_out) else
                note_failure("output not held under back-pressure");
        end
        @(posedge clk);
        s_valid <= 1'b0;
        m_ready <= 1'b1;
        fill_frame(1'b1, '0);
        send_frame(1'b0);
        check_frame("frame after release");
        finish_test("back-pressure");

        fill_frame(1'b0, '0);
        send_frame(1'b0);
        check_frame("zero frame");
        assert (last_out == '0) else note_failure("zero frame gave nonzero energy");
        finish_test("zero frame");

        assert_fails = mel_filter_bank_top_inst.mel_assertions_inst.fail_count;
        $display("tests %0d, failed tests %0d, check errors %0d, assertion failures %0d",
                 test_count, failed_tests, error_count, assert_fails);
        if (failed_tests == 0 && error_count == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
